/* logic/isa_pkg.sv */
package isa_pkg;

    // ====================================================================
    // Basic machine types
    // ====================================================================
    typedef logic [7:0] data_t;  // One byte on the internal bus
    typedef logic [7:0] addr_t;  // Flat 256-byte address space

    // ====================================================================
    // Opcode encodings
    // ====================================================================
    typedef enum logic [7:0] {
        NOP   = 8'h00,  // No operation
        HLT   = 8'h01,  // Stop until reset
        LDI_A = 8'h0C,  // A <= immediate
        LDA   = 8'h0D,  // A <= mem[addr]
        ADD   = 8'h10,  // A <= A + mem[addr]
        SUB   = 8'h11,  // A <= A - mem[addr]
        STA   = 8'h14,  // mem[addr] <= A
        JMP   = 8'h20,  // PC <= addr
        JZ    = 8'h21,  // Jump if zero set
        JC    = 8'h22,  // Jump if carry set
        OUT   = 8'h30   // Output register <= A
    } opcode_t;

    // ====================================================================
    // Flag vector layout
    // ====================================================================
    typedef logic [2:0] flags_t;

    localparam int FLAG_ZERO  = 0;  // Last loaded value was zero
    localparam int FLAG_CARRY = 1;  // Adder carry, or no borrow on SUB
    localparam int FLAG_NEG   = 2;  // Bit 7 of last loaded value

endpackage

/* logic/control_pkg.sv */
package control_pkg;

    // ====================================================================
    // One control bit per datapath action
    // ====================================================================
    typedef struct packed {
        // At most one bus driver per cycle
        logic oe_pc;        // PC onto bus
        logic oe_ram;       // RAM read data onto bus
        logic oe_temp;      // Operand register onto bus
        logic oe_a;         // Accumulator onto bus
        logic oe_alu;       // ALU result onto bus
        // Register loads
        logic load_mar_pc;  // MAR <= PC for a fetch
        logic load_mar;     // MAR <= bus
        logic load_ir;      // IR <= bus
        logic load_temp;    // TEMP <= bus
        logic load_a;       // A <= bus
        logic load_pc;      // PC <= bus on a jump
        logic load_flags;   // Flags from bus value
        logic write_ram;    // mem[MAR] <= bus
        logic load_out;     // Output register <= bus
        // Misc controls
        logic pc_enable;    // PC increment
        logic alu_sub;      // ALU subtracts
        // Jump qualifiers
        logic check_zero;   // load_pc only if zero set
        logic check_carry;  // load_pc only if carry set
        // Sequencing
        logic halt;         // Enter S_HALT
        logic last_step;    // Final row of the instruction
    } control_word_t;

    // ====================================================================
    // Sequencer state and microstep counter
    // ====================================================================
    typedef enum logic [2:0] {
        S_RESET          = 3'd0,
        S_LATCH_ADDR     = 3'd1,
        S_READ_BYTE      = 3'd2,
        S_LATCH_BYTE     = 3'd3,
        S_CHK_MORE_BYTES = 3'd4,
        S_EXECUTE        = 3'd5,
        S_HALT           = 3'd6
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

endpackage

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  isa_pkg::opcode_t            opcode,
    input  isa_pkg::flags_t             flags,
    input  logic                        out_full,
    output control_pkg::control_word_t  control_word,
    output logic                        halted
);
    import isa_pkg::*;
    import control_pkg::*;

    fsm_state_t    current_state;       // Sequencer state
    fsm_state_t    next_state;
    microstep_t    current_step;        // Row within the opcode
    microstep_t    next_step;
    logic [1:0]    current_byte_count;  // Bytes fetched so far
    logic [1:0]    next_byte_count;
    logic          num_operands;        // 0 or 1 operand byte
    logic          opcode_known;        // Decoded as a legal opcode
    control_word_t rom_word;            // Raw microcode row
    logic          jump_ok;             // Jump qualifier passes
    logic          out_stall;           // OUT row blocked by full register

    // ====================================================================
    // Opcode decode and operand count
    // ====================================================================
    always_comb begin
        opcode_known = 1'b1;
        num_operands = 1'b0;
        case (opcode)
            NOP, HLT, OUT: num_operands = 1'b0;
            LDI_A, LDA, ADD, SUB, STA, JMP, JZ, JC: num_operands = 1'b1;
            default: opcode_known = 1'b0;  // Illegal opcode halts after fetch
        endcase
    end

    // ====================================================================
    // Microcode ROM
    // ====================================================================
    function automatic control_word_t microcode(opcode_t op, microstep_t ms);
        control_word_t row;
        row = '{default: 1'b0, halt: 1'b1};  // Undefined rows halt
        case (op)
            NOP: if (ms == MS0) row = '{default: 1'b0, last_step: 1'b1};
            LDI_A: if (ms == MS0) begin
                row = '{default: 1'b0, oe_temp: 1'b1, load_a: 1'b1,
                        load_flags: 1'b1, last_step: 1'b1};
            end
            LDA: case (ms)
                MS0: row = '{default: 1'b0, oe_temp: 1'b1, load_mar: 1'b1};
                MS1: row = '{default: 1'b0, oe_ram: 1'b1, load_a: 1'b1,
                             load_flags: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            ADD, SUB: case (ms)
                MS0: row = '{default: 1'b0, oe_temp: 1'b1, load_mar: 1'b1};
                MS1: row = '{default: 1'b0, oe_ram: 1'b1, load_temp: 1'b1};
                MS2: row = '{default: 1'b0, oe_alu: 1'b1, load_a: 1'b1, load_flags: 1'b1,
                             alu_sub: (op == SUB), last_step: 1'b1};
                default: ;
            endcase
            STA: case (ms)
                MS0: row = '{default: 1'b0, oe_temp: 1'b1, load_mar: 1'b1};
                MS1: row = '{default: 1'b0, oe_a: 1'b1, write_ram: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            JMP, JZ, JC: if (ms == MS0) begin
                row = '{default: 1'b0, oe_temp: 1'b1, load_pc: 1'b1,
                        check_zero: (op == JZ), check_carry: (op == JC), last_step: 1'b1};
            end
            OUT: if (ms == MS0) begin
                row = '{default: 1'b0, oe_a: 1'b1, load_out: 1'b1, last_step: 1'b1};
            end
            default: ;  // HLT and unknown keep the halt row
        endcase
        return row;
    endfunction

    assign rom_word  = microcode(opcode, current_step);
    assign jump_ok   = !(rom_word.check_zero || rom_word.check_carry) ||
                       (rom_word.check_zero && flags[FLAG_ZERO]) ||
                       (rom_word.check_carry && flags[FLAG_CARRY]);
    assign out_stall = rom_word.load_out && out_full;  // Wait for drain
    assign halted    = (current_state == S_HALT);

    // ====================================================================
    // State registers
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            current_state      <= S_RESET;
            current_step       <= MS0;
            current_byte_count <= 2'd0;
        end else begin
            current_state      <= next_state;
            current_step       <= next_step;
            current_byte_count <= next_byte_count;
        end
    end

    // ====================================================================
    // Next state and control word
    // ====================================================================
    always_comb begin
        next_state      = current_state;
        next_step       = current_step;
        next_byte_count = current_byte_count;
        control_word    = '0;
        case (current_state)
            S_RESET: next_state = S_LATCH_ADDR;
            S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;  // Address of next byte
                next_state = S_READ_BYTE;
            end
            S_READ_BYTE: next_state = S_LATCH_BYTE;  // RAM read in flight
            S_LATCH_BYTE: begin
                control_word.oe_ram    = 1'b1;
                control_word.pc_enable = 1'b1;
                if (current_byte_count == 2'd0) control_word.load_ir = 1'b1;
                else control_word.load_temp = 1'b1;  // Operand byte
                next_byte_count = current_byte_count + 2'd1;
                next_state = S_CHK_MORE_BYTES;
            end
            S_CHK_MORE_BYTES: begin
                if (!opcode_known) begin
                    next_state = S_HALT;
                end else if (current_byte_count > {1'b0, num_operands}) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;  // Fetch operand
                end
            end
            S_EXECUTE: begin
                if (!out_stall) begin  // Stalled row drives nothing
                    control_word = rom_word;
                    if (!jump_ok) control_word.load_pc = 1'b0;  // Branch not taken
                    if (rom_word.halt) begin
                        next_state = S_HALT;
                        next_step  = MS0;
                    end else if (rom_word.last_step) begin
                        next_state = S_LATCH_ADDR;
                        next_step  = MS0;
                    end else begin
                        next_step = microstep_t'(current_step + 3'd1);
                    end
                end
            end
            S_HALT: next_state = S_HALT;  // Only reset leaves
            default: next_state = S_HALT;
        endcase
    end

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                        clk,
    input  logic                        reset,
    input  control_pkg::control_word_t  control_word,
    input  isa_pkg::data_t              rd_data,
    input  logic                        out_ready,
    output isa_pkg::addr_t              mem_addr,
    output isa_pkg::data_t              wr_data,
    output isa_pkg::opcode_t            ir_opcode,
    output isa_pkg::flags_t             flags,
    output logic                        out_full,
    output isa_pkg::data_t              out_data
);
    import isa_pkg::*;

    addr_t pc;          // Program counter
    addr_t mar;         // Memory address register
    data_t a_reg;       // Accumulator
    data_t temp;        // Operand register
    data_t out_reg;     // Output holding register
    data_t bus;         // Internal byte bus
    data_t alu_result;
    logic  alu_carry;   // Carry out, or no borrow

    // ====================================================================
    // Bus mux and ALU
    // ====================================================================
    always_comb begin
        bus = '0;  // Idle bus reads zero
        if (control_word.oe_pc) bus = pc;
        else if (control_word.oe_ram) bus = rd_data;
        else if (control_word.oe_temp) bus = temp;
        else if (control_word.oe_a) bus = a_reg;
        else if (control_word.oe_alu) bus = alu_result;
    end

    always_comb begin
        if (control_word.alu_sub) begin  // A + ~TEMP + 1
            {alu_carry, alu_result} = {1'b0, a_reg} + {1'b0, ~temp} + 9'd1;
        end else begin
            {alu_carry, alu_result} = {1'b0, a_reg} + {1'b0, temp};
        end
    end

    // MAR bypass lets the RAM see a new address in the cycle it loads
    assign mem_addr = control_word.load_mar ? bus : mar;
    assign wr_data  = bus;
    assign out_data = out_reg;  // Stable while out_full

    // ====================================================================
    // Architectural state
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            a_reg    <= '0;
            flags    <= '0;
            out_full <= 1'b0;
        end else begin
            if (control_word.pc_enable) pc <= pc + 8'd1;
            else if (control_word.load_pc) pc <= bus;
            if (control_word.load_a) a_reg <= bus;
            if (control_word.load_flags) begin
                flags[FLAG_ZERO]  <= (bus == '0);
                flags[FLAG_CARRY] <= control_word.oe_alu && alu_carry;  // Loads clear it
                flags[FLAG_NEG]   <= bus[7];
            end
            if (control_word.load_out) out_full <= 1'b1;
            else if (out_full && out_ready) out_full <= 1'b0;  // Byte taken
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (control_word.load_mar_pc) mar <= pc;
        else if (control_word.load_mar) mar <= bus;
        if (control_word.load_ir) ir_opcode <= opcode_t'(bus);
        if (control_word.load_temp) temp <= bus;
        if (control_word.load_out) out_reg <= bus;  // Only when not full
    end

endmodule

/* logic/program_ram.sv */
`timescale 1ns/1ps

module program_ram (
    input  logic            clk,
    input  logic            reset,
    input  logic            prog_we,
    input  isa_pkg::addr_t  prog_addr,
    input  isa_pkg::data_t  prog_data,
    input  logic            write_ram,
    input  isa_pkg::addr_t  mem_addr,
    input  isa_pkg::data_t  wr_data,
    output isa_pkg::data_t  rd_data
);
    import isa_pkg::*;

    data_t mem [256];  // Program and data share one space

    always_ff @(posedge clk) begin
        if (reset) begin
            if (prog_we) mem[prog_addr] <= prog_data;  // Loader owns the port
        end else if (write_ram) begin
            mem[mem_addr] <= wr_data;  // STA
        end
        rd_data <= mem[mem_addr];  // One cycle read latency
    end

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            prog_we,
    input  isa_pkg::addr_t  prog_addr,
    input  isa_pkg::data_t  prog_data,
    input  logic            out_ready,
    output logic            out_valid,
    output isa_pkg::data_t  out_data,
    output logic            halted
);
    import isa_pkg::*;
    import control_pkg::*;

    control_word_t control_word;
    opcode_t       ir_opcode;
    flags_t        flags;
    logic          out_full;  // Output register occupied
    addr_t         mem_addr;
    data_t         wr_data;
    data_t         rd_data;

    assign out_valid = out_full;

    control_unit u_control (
        .clk          (clk),
        .reset        (reset),
        .opcode       (ir_opcode),
        .flags        (flags),
        .out_full     (out_full),
        .control_word (control_word),
        .halted       (halted)
    );

    datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .rd_data      (rd_data),
        .out_ready    (out_ready),
        .mem_addr     (mem_addr),
        .wr_data      (wr_data),
        .ir_opcode    (ir_opcode),
        .flags        (flags),
        .out_full     (out_full),
        .out_data     (out_data)
    );

    program_ram u_ram (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .write_ram (control_word.write_ram),
        .mem_addr  (mem_addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data)
    );

endmodule

/* test/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic                        clk,
    input logic                        reset,
    input control_pkg::fsm_state_t     current_state,
    input control_pkg::control_word_t  control_word,
    input isa_pkg::flags_t             flags,
    input logic                        halted
);
    import isa_pkg::*;
    import control_pkg::*;

    // ====================================================================
    // Sequencer checks
    // ====================================================================
    single_bus_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({control_word.oe_pc, control_word.oe_ram, control_word.oe_temp,
                  control_word.oe_a, control_word.oe_alu}))
        else $error("More than one bus driver enabled");

    // Only reset leaves S_HALT
    halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped while reset was low");

    jz_untaken_keeps_pc: assert property (@(posedge clk) disable iff (reset)
        (current_state == S_EXECUTE && control_word.check_zero && !flags[FLAG_ZERO])
        |-> !control_word.load_pc)
        else $error("JZ loaded PC with the zero flag clear");

endmodule

bind control_unit cpu_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .current_state (current_state),
    .control_word  (control_word),
    .flags         (flags),
    .halted        (halted)
);

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import isa_pkg::*;

    localparam int unsigned MAX_CYCLES = 20000;  // Six short runs, 200-cycle waits, stalls
    localparam logic [31:0] SEED       = 32'd22;

    logic         clk;
    logic         reset;
    logic         prog_we;
    addr_t        prog_addr;
    data_t        prog_data;
    logic         out_ready = 1'b0;
    logic         out_valid;
    data_t        out_data;
    logic         halted;

    data_t        image [256];          // Model copy of loaded RAM
    addr_t        load_addr_q [$];      // Bytes to write during reset
    data_t        load_data_q [$];
    data_t        expected_q [$];       // OUT bytes still owed
    addr_t        build_addr;           // Next program byte
    logic [31:0]  data_rng = SEED;
    logic [31:0]  ready_rng = SEED;
    logic         use_backpressure = 1'b0;
    logic         hold_pending = 1'b0;  // Byte offered but not taken
    data_t        held_data = '0;
    int unsigned  cycle_count = 0;
    int unsigned  total_expected = 0;
    int unsigned  total_checked = 0;
    logic         run_passed = 1'b0;
    logic         failure_reported = 1'b0;

    cpu_top dut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // ====================================================================
    // Random source and error handling
    // ====================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t random_byte();
        data_rng = xorshift32(data_rng);
        return data_rng[7:0];
    endfunction

    task automatic abort_run(input string reason);
        failure_reported = 1'b1;
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_out_data(input data_t actual, input data_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t: %s is %02h, expected %02h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_halted(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t: %s halted is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    // ====================================================================
    // Program building
    // ====================================================================
    task automatic new_program();
        foreach (image[i]) image[i] = '0;
        load_addr_q.delete();
        load_data_q.delete();
        build_addr = '0;
    endtask

    task automatic put_byte(input addr_t addr, input data_t value);
        image[addr] = value;
        load_addr_q.push_back(addr);
        load_data_q.push_back(value);
    endtask

    task automatic emit(input data_t value);
        put_byte(build_addr, value);
        build_addr = build_addr + 8'd1;
    endtask

    task automatic emit_instr(input data_t op, input data_t operand);
        emit(op);
        emit(operand);
    endtask

    task automatic build_immediates();
        new_program();
        repeat (6) begin
            emit_instr(LDI_A, random_byte());
            emit(OUT);
        end
        emit(HLT);
    endtask

    task automatic build_arithmetic();
        new_program();
        for (int k = 0; k < 4; k++) put_byte(addr_t'(8'h80 + k), random_byte());
        emit_instr(LDA, 8'h80);
        emit_instr(ADD, 8'h81);
        emit_instr(STA, 8'h90);
        emit_instr(LDI_A, 8'h00);  // Clear A so the reload is visible
        emit_instr(LDA, 8'h90);
        emit(OUT);
        emit_instr(LDA, 8'h82);
        emit_instr(SUB, 8'h83);
        emit_instr(STA, 8'h91);
        emit_instr(LDI_A, 8'h00);
        emit_instr(LDA, 8'h91);
        emit(OUT);
        emit(HLT);
    endtask

    task automatic build_countdown(input data_t start);
        new_program();
        put_byte(8'hF0, 8'd3);       // Step size
        emit_instr(LDI_A, start);    // 00
        emit(OUT);                   // 02 loop top
        emit_instr(SUB, 8'hF0);      // 03
        emit_instr(JZ, 8'h0D);       // 05 exact zero
        emit_instr(JC, 8'h02);       // 07 keep going while no borrow
        emit(OUT);                   // 09 wrapped value
        emit_instr(JMP, 8'h0E);      // 0A
        emit(HLT);                   // 0C skipped
        emit(OUT);                   // 0D
        emit(HLT);                   // 0E
    endtask

    task automatic build_undefined();
        new_program();
        emit_instr(LDI_A, random_byte());
        emit(OUT);
        emit(8'hFF);  // Not an opcode
        emit(OUT);    // Never reached
        emit(HLT);
    endtask

    // ====================================================================
    // ISA reference model
    // ====================================================================
    function automatic logic reference_outputs();
        data_t      mem [256];
        addr_t      pc;
        data_t      acc;
        data_t      op;
        data_t      operand;
        logic [8:0] sum;
        logic       zero;
        logic       carry;
        logic       done;
        int         steps;
        mem   = image;
        pc    = '0;
        acc   = '0;
        zero  = 1'b0;
        carry = 1'b0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            op      = mem[pc];
            operand = mem[pc + 8'd1];
            pc      = pc + 8'd1;
            if (op inside {LDI_A, LDA, ADD, SUB, STA, JMP, JZ, JC}) pc = pc + 8'd1;
            case (op)
                NOP: ;
                LDI_A, LDA: begin
                    acc   = (op == LDI_A) ? operand : mem[operand];
                    carry = 1'b0;  // Loads clear carry
                end
                ADD: begin
                    sum   = {1'b0, acc} + {1'b0, mem[operand]};
                    acc   = sum[7:0];
                    carry = sum[8];
                end
                SUB: begin
                    carry = (acc >= mem[operand]);  // Set when no borrow
                    acc   = acc - mem[operand];
                end
                STA: mem[operand] = acc;
                JMP: pc = operand;
                JZ: if (zero) pc = operand;
                JC: if (carry) pc = operand;
                OUT: expected_q.push_back(acc);
                default: done = 1'b1;  // HLT or undefined byte
            endcase
            if (op inside {LDI_A, LDA, ADD, SUB}) zero = (acc == 8'd0);
            steps++;
        end
        return done;
    endfunction

    // ====================================================================
    // Stimulus
    // ====================================================================
    always @(posedge clk) begin
        if (use_backpressure) begin
            ready_rng = xorshift32(ready_rng);
            out_ready <= (ready_rng % 32'd10) < 32'd6;  // About 60% ready
        end else begin
            out_ready <= 1'b1;
        end
    end

    task automatic load_and_reset();
        int n;
        n = (load_addr_q.size() > 15) ? load_addr_q.size() : 15;  // At least 16 edges
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            prog_we <= (i < load_addr_q.size());
            if (i < load_addr_q.size()) begin
                prog_addr <= load_addr_q[i];
                prog_data <= load_data_q[i];
            end
        end
        @(posedge clk);  // Last byte lands here
        prog_we <= 1'b0;
        reset   <= 1'b0;
    endtask

    task automatic run_program(input logic backpressure, input string name);
        logic model_halts;
        expected_q.delete();
        model_halts      = reference_outputs();
        total_expected   = total_expected + expected_q.size();
        use_backpressure = backpressure;
        load_and_reset();
        @(negedge clk);
        while (!(halted && !out_valid && expected_q.size() == 0)) begin
            if (!out_valid && expected_q.size() != 0) begin  // Bytes still owed
                check_halted(halted, 1'b0,
                             $sformatf("%s with %0d bytes owed", name, expected_q.size()));
            end
            @(negedge clk);
        end
        repeat (200) begin  // Quiet window after halt
            @(negedge clk);
            if (out_valid) abort_run($sformatf("%s: out_valid rose after the CPU halted", name));
            check_halted(halted, model_halts, name);
        end
    endtask

    // ====================================================================
    // Compare process and timeout
    // ====================================================================
    always @(posedge clk) begin
        if (reset) begin
            hold_pending <= 1'b0;
        end else begin
            if (hold_pending) begin  // Previous edge offered without ready
                if (out_valid !== 1'b1) abort_run("out_valid dropped before the byte was taken");
                check_out_data(out_data, held_data, "out_data while stalled");
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    abort_run("DUT sent a byte that the model did not predict");
                end else begin
                    check_out_data(out_data, expected_q.pop_front(), "out_data");
                    total_checked++;
                end
            end
            hold_pending <= out_valid && !out_ready;
            held_data    <= out_data;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, run exceeded %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        data_t start;
        reset     <= 1'b1;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        build_immediates();
        run_program(1'b0, "immediates");
        run_program(1'b1, "back-pressure");  // Same image, same byte order
        build_arithmetic();
        run_program(1'b1, "arithmetic");
        start = data_t'(3 * (2 + (random_byte() % 4)));  // Multiple of the step
        build_countdown(start);
        run_program(1'b0, "countdown to zero");
        build_countdown(start + 8'd1);
        run_program(1'b1, "countdown with borrow");
        build_undefined();
        run_program(1'b1, "undefined opcode");
        if (total_checked == total_expected && total_checked != 0) begin
            run_passed = 1'b1;
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d expected bytes were checked",
                                total_checked, total_expected));
        end
    end

    // Run ended by a failed assertion
    final begin
        if (!run_passed && !failure_reported) $display("TEST FAILED");
    end

endmodule

/* micro_cpu.f */
logic/isa_pkg.sv
logic/control_pkg.sv
logic/control_unit.sv
logic/datapath.sv
logic/program_ram.sv
logic/cpu_top.sv
test/cpu_assertions.sv
test/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the micro CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -f micro_cpu.f -o cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0
